//--- verilog/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  regAddr_t;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,  // R-type, decoded further by funct
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnNor  = 6'h27,
        fnSlt  = 6'h2a,
        fnSltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu, aluSll, aluSrl
    } aluOp_t;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   regDst;      // rd when set, rt otherwise
        logic   aluSrc;      // immediate as second operand
        logic   zeroExtend;
        logic   shiftImm;    // sll/srl, shift amount from shamt
        logic   luiOp;
        logic   branchEq;
        logic   branchNe;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instruction;
    } ifId_t;

    typedef struct packed {
        logic       valid;
        ctrl_t      ctrl;
        word_t      pcPlus4;
        word_t      readData1;
        word_t      readData2;
        word_t      extImm;
        logic [4:0] shamt;
        regAddr_t   destReg;
    } idEx_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t destReg;
    } exMem_t;

    typedef struct packed {
        logic     valid;
        logic     regWrite;
        regAddr_t destReg;
        word_t    wbData;
    } memWb_t;

endpackage

//--- verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic              Clk,
    input  logic              rstN,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    input  mipsPkg::regAddr_t wrAddr,
    input  mipsPkg::word_t    wrData,
    input  logic              wrEnable,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData
);

    mipsPkg::word_t regs [32];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wrEnable && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle write goes straight to the readers
    assign rsData = (rsAddr == '0) ? '0 :
                    (wrEnable && wrAddr == rsAddr) ? wrData : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wrEnable && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

//--- verilog/controller.sv
`timescale 1ns/1ps

module controller (
    input  mipsPkg::word_t instruction,
    output mipsPkg::ctrl_t ctrl
);

    mipsPkg::opcode_t opcode;
    mipsPkg::funct_t  funct;

    assign opcode = mipsPkg::opcode_t'(instruction[31:26]);
    assign funct  = mipsPkg::funct_t'(instruction[5:0]);

    always_comb begin
        ctrl = '0;  // anything unrecognised runs as a nop
        case (opcode)
            mipsPkg::opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (funct)
                    mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  ctrl.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  ctrl.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnNor:  ctrl.aluOp = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: ctrl.aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnSll: begin
                        ctrl.aluOp    = mipsPkg::aluSll;
                        ctrl.shiftImm = 1'b1;
                    end
                    mipsPkg::fnSrl: begin
                        ctrl.aluOp    = mipsPkg::aluSrl;
                        ctrl.shiftImm = 1'b1;
                    end
                    default: ctrl = '0;
                endcase
            end
            mipsPkg::opAddiu: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluAdd;
            end
            mipsPkg::opSlti: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluSlt;  // signed compare on sign-extended imm
            end
            mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.zeroExtend = 1'b1;
                ctrl.aluOp      = (opcode == mipsPkg::opAndi) ? mipsPkg::aluAnd :
                                  (opcode == mipsPkg::opOri)  ? mipsPkg::aluOr  :
                                                                mipsPkg::aluXor;
            end
            mipsPkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.luiOp    = 1'b1;
            end
            mipsPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluAdd;
            end
            mipsPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluAdd;
            end
            mipsPkg::opBeq: ctrl.branchEq = 1'b1;
            mipsPkg::opBne: ctrl.branchNe = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

//--- verilog/fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
    parameter int imemDepth = 256
) (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           imemWe,
    input  mipsPkg::word_t imemAddr,
    input  mipsPkg::word_t imemData,
    input  logic           stall,
    input  logic           redirect,
    input  mipsPkg::word_t redirectPc,
    output mipsPkg::ifId_t ifId
);

    localparam int idxW = $clog2(imemDepth);

    mipsPkg::word_t imem [imemDepth];
    mipsPkg::word_t pc;

    // program load, only while the core is held in reset
    always_ff @(posedge Clk) begin
        if (imemWe && !rstN)
            imem[imemAddr[idxW+1:2]] <= imemData;
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin  // payload holds while decode is blocked
            ifId.pc          <= pc;
            ifId.instruction <= imem[pc[idxW+1:2]];
        end
        if (!rstN) begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end else if (redirect) begin  // taken branch wins over a stall
            pc         <= redirectPc;
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            pc         <= pc + 32'd4;
            ifId.valid <= 1'b1;
        end
    end

    loadOnlyInReset: assert property (@(posedge Clk) imemWe |-> !rstN)
        else $error("instruction memory write while core is running");

endmodule

//--- verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic            Clk,
    input  logic            rstN,
    input  mipsPkg::ifId_t  ifId,
    input  mipsPkg::memWb_t wbEntry,
    input  mipsPkg::exMem_t exEntry,
    input  logic            redirect,
    output mipsPkg::idEx_t  idEx,
    output logic            stall
);

    mipsPkg::regAddr_t rs, rt, rd;
    mipsPkg::word_t    rsData, rtData, extImm;
    mipsPkg::ctrl_t    ctrl;
    logic [15:0]       imm;
    logic              usesRs, usesRt;
    logic              hitEx, hitMem;

    assign rs  = ifId.instruction[25:21];
    assign rt  = ifId.instruction[20:16];
    assign rd  = ifId.instruction[15:11];
    assign imm = ifId.instruction[15:0];

    registerFile i_registerFile (
        .Clk      (Clk),
        .rstN     (rstN),
        .rsAddr   (rs),
        .rtAddr   (rt),
        .wrAddr   (wbEntry.destReg),
        .wrData   (wbEntry.wbData),
        .wrEnable (wbEntry.valid && wbEntry.regWrite),
        .rsData   (rsData),
        .rtData   (rtData)
    );

    controller i_controller (
        .instruction (ifId.instruction),
        .ctrl        (ctrl)
    );

    assign extImm = ctrl.zeroExtend ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    // which fields are real sources for this instruction
    assign usesRs = !(ctrl.shiftImm || ctrl.luiOp);
    assign usesRt = ctrl.regDst || ctrl.memWrite || ctrl.branchEq || ctrl.branchNe;

    // producer one ahead, still in execute
    assign hitEx = idEx.valid && idEx.ctrl.regWrite && idEx.destReg != '0 &&
                   ((usesRs && idEx.destReg == rs) || (usesRt && idEx.destReg == rt));

    // producer two ahead, in memory; three ahead is covered by write-through
    assign hitMem = exEntry.valid && exEntry.ctrl.regWrite && exEntry.destReg != '0 &&
                    ((usesRs && exEntry.destReg == rs) || (usesRt && exEntry.destReg == rt));

    assign stall = ifId.valid && (hitEx || hitMem);

    always_ff @(posedge Clk) begin
        idEx.ctrl      <= ctrl;
        idEx.pcPlus4   <= ifId.pc + 32'd4;
        idEx.readData1 <= rsData;
        idEx.readData2 <= rtData;
        idEx.extImm    <= extImm;
        idEx.shamt     <= ifId.instruction[10:6];
        idEx.destReg   <= ctrl.regDst ? rd : rt;
        if (!rstN)
            idEx.valid <= 1'b0;
        else
            idEx.valid <= ifId.valid && !stall && !redirect;  // bubble or squash
    end

    // the producer leaves memory after two bubbles at most
    stallAtMostTwo: assert property (@(posedge Clk) disable iff (!rstN)
        (stall && $past(stall)) |=> !stall)
        else $error("decode stall held for more than two cycles");

endmodule

//--- verilog/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic            Clk,
    input  logic            rstN,
    input  mipsPkg::idEx_t  idEx,
    output mipsPkg::exMem_t exMem,
    output logic            redirect,
    output mipsPkg::word_t  redirectPc
);

    mipsPkg::word_t opA, opB, aluResult;
    logic           isBranch, equal;

    assign opA = idEx.readData1;
    assign opB = idEx.ctrl.aluSrc ? idEx.extImm : idEx.readData2;

    always_comb begin
        case (idEx.ctrl.aluOp)
            mipsPkg::aluAdd:  aluResult = opA + opB;
            mipsPkg::aluSub:  aluResult = opA - opB;
            mipsPkg::aluAnd:  aluResult = opA & opB;
            mipsPkg::aluOr:   aluResult = opA | opB;
            mipsPkg::aluXor:  aluResult = opA ^ opB;
            mipsPkg::aluNor:  aluResult = ~(opA | opB);
            mipsPkg::aluSlt:  aluResult = {31'b0, $signed(opA) < $signed(opB)};
            mipsPkg::aluSltu: aluResult = {31'b0, opA < opB};
            mipsPkg::aluSll:  aluResult = idEx.readData2 << idEx.shamt;  // shifts act on rt
            mipsPkg::aluSrl:  aluResult = idEx.readData2 >> idEx.shamt;
            default:          aluResult = opA + opB;
        endcase
        if (idEx.ctrl.luiOp)
            aluResult = {idEx.extImm[15:0], 16'h0000};
    end

    // branch resolution
    assign isBranch   = idEx.ctrl.branchEq || idEx.ctrl.branchNe;
    assign equal      = idEx.readData1 == idEx.readData2;
    assign redirect   = idEx.valid &&
                        ((idEx.ctrl.branchEq && equal) || (idEx.ctrl.branchNe && !equal));
    assign redirectPc = idEx.pcPlus4 + {idEx.extImm[29:0], 2'b00};

    always_ff @(posedge Clk) begin
        exMem.ctrl      <= idEx.ctrl;
        exMem.aluResult <= aluResult;
        exMem.storeData <= idEx.readData2;
        exMem.destReg   <= idEx.destReg;
        if (!rstN)
            exMem.valid <= 1'b0;
        else
            exMem.valid <= idEx.valid && !isBranch;  // branches end here
    end

endmodule

//--- verilog/memoryStage.sv
`timescale 1ns/1ps

module memoryStage #(
    parameter int dmemDepth = 256
) (
    input  logic            Clk,
    input  logic            rstN,
    input  mipsPkg::exMem_t exMem,
    output mipsPkg::memWb_t memWb,
    output logic            storeValid,
    output mipsPkg::word_t  storeAddr,
    output mipsPkg::word_t  storeData
);

    localparam int idxW = $clog2(dmemDepth);

    mipsPkg::word_t  dmem [dmemDepth];
    logic [idxW-1:0] index;
    mipsPkg::word_t  loadData;

    assign index      = exMem.aluResult[idxW+1:2];  // word addressed
    assign loadData   = dmem[index];
    assign storeValid = exMem.valid && exMem.ctrl.memWrite;
    assign storeAddr  = exMem.aluResult;
    assign storeData  = exMem.storeData;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < dmemDepth; i++)
                dmem[i] <= '0;
        end else if (storeValid) begin
            dmem[index] <= exMem.storeData;
        end
    end

    always_ff @(posedge Clk) begin
        memWb.regWrite <= exMem.ctrl.regWrite;
        memWb.destReg  <= exMem.destReg;
        memWb.wbData   <= exMem.ctrl.memToReg ? loadData : exMem.aluResult;
        if (!rstN)
            memWb.valid <= 1'b0;
        else
            memWb.valid <= exMem.valid;
    end

    wordAligned: assert property (@(posedge Clk) disable iff (!rstN)
        (exMem.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite))
            |-> exMem.aluResult[1:0] == 2'b00)
        else $error("unaligned data access at %h", exMem.aluResult);

endmodule

//--- verilog/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  mipsPkg::word_t    imemAddr,
    input  mipsPkg::word_t    imemData,
    output logic              retireValid,
    output mipsPkg::regAddr_t retireReg,
    output mipsPkg::word_t    retireData,
    output logic              storeValid,
    output mipsPkg::word_t    storeAddr,
    output mipsPkg::word_t    storeData
);

    mipsPkg::ifId_t  ifId;
    mipsPkg::idEx_t  idEx;
    mipsPkg::exMem_t exMem;
    mipsPkg::memWb_t memWb;
    logic            stall;
    logic            redirect;
    mipsPkg::word_t  redirectPc;

    fetchStage #(.imemDepth(imemDepth)) i_fetchStage (
        .Clk        (Clk),
        .rstN       (rstN),
        .imemWe     (imemWe),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .ifId       (ifId)
    );

    decodeStage i_decodeStage (
        .Clk      (Clk),
        .rstN     (rstN),
        .ifId     (ifId),
        .wbEntry  (memWb),   // register file write side
        .exEntry  (exMem),
        .redirect (redirect),
        .idEx     (idEx),
        .stall    (stall)
    );

    executeStage i_executeStage (
        .Clk        (Clk),
        .rstN       (rstN),
        .idEx       (idEx),
        .exMem      (exMem),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    memoryStage #(.dmemDepth(dmemDepth)) i_memoryStage (
        .Clk        (Clk),
        .rstN       (rstN),
        .exMem      (exMem),
        .memWb      (memWb),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    // writes to register 0 are not architectural events
    assign retireValid = memWb.valid && memWb.regWrite && memWb.destReg != '0;
    assign retireReg   = memWb.destReg;
    assign retireData  = memWb.wbData;

endmodule

//--- tb/mipsChecker.sv
`timescale 1ns/1ps

module mipsChecker (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  mipsPkg::word_t    imemAddr,
    input  mipsPkg::word_t    imemData,
    input  logic              retireValid,
    input  mipsPkg::regAddr_t retireReg,
    input  mipsPkg::word_t    retireData,
    input  logic              storeValid,
    input  mipsPkg::word_t    storeAddr,
    input  mipsPkg::word_t    storeData,
    output int                testsRun,
    output int                testsFailed,
    output int                errorCount
);

    mipsPkg::word_t prog [256];    // copy of the loaded program
    logic [36:0]    expRetire [$]; // {reg, data}
    logic [63:0]    expStore [$];  // {addr, data}
    logic [36:0]    retireExp;
    logic [63:0]    storeExp;
    int             testErrors;
    logic           running = 1'b0;

    always @(posedge Clk) begin
        if (imemWe && !rstN)
            prog[imemAddr[9:2]] <= imemData;
    end

    // ISA level model, one instruction per step and no delay slot
    function automatic void runReference();
        mipsPkg::word_t regs [32];
        mipsPkg::word_t mem [256];
        mipsPkg::word_t ins, a, b, se, res, addr, pc;
        logic [4:0]     dst;
        logic           wr;
        int             progEnd;
        int             steps;
        regs = '{default: 32'h0};
        mem = '{default: 32'h0};
        pc = '0;
        steps = 0;
        progEnd = 0;
        for (int i = 0; i < 256; i++)
            if (prog[i] != '0)
                progEnd = i + 1;  // zero words past this are nops
        expRetire.delete();
        expStore.delete();
        while (pc < progEnd * 4 && steps < 1000) begin
            ins = prog[pc[9:2]];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            se = {{16{ins[15]}}, ins[15:0]};
            addr = a + se;
            dst = ins[20:16];
            wr = 1'b1;
            res = '0;
            pc = pc + 4;
            steps++;
            case (ins[31:26])
                6'h00: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        6'h00: res = b << ins[10:6];
                        6'h02: res = b >> ins[10:6];
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h27: res = ~(a | b);
                        6'h2a: res = {31'b0, $signed(a) < $signed(b)};
                        6'h2b: res = {31'b0, a < b};
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = a + se;
                6'h0a: res = {31'b0, $signed(a) < $signed(se)};
                6'h0c: res = a & {16'h0, ins[15:0]};
                6'h0d: res = a | {16'h0, ins[15:0]};
                6'h0e: res = a ^ {16'h0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'h0};
                6'h23: res = mem[addr[9:2]];
                6'h2b: begin
                    wr = 1'b0;
                    mem[addr[9:2]] = b;
                    expStore.push_back({addr, b});
                end
                6'h04: begin
                    wr = 1'b0;
                    if (a == b)
                        pc = pc + (se << 2);
                end
                6'h05: begin
                    wr = 1'b0;
                    if (a != b)
                        pc = pc + (se << 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                expRetire.push_back({dst, res});
            end
        end
        if (pc < progEnd * 4) begin
            $display("test %0d: reference model stopped at its step limit", testsRun + 1);
            testErrors++;
        end
    endfunction

    task automatic compareField(string name, mipsPkg::word_t expected, mipsPkg::word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, actual %h", name, expected, actual);
            testErrors++;
        end
    endtask

    always @(posedge rstN) begin
        testErrors = 0;
        runReference();
        running = 1'b1;
    end

    // events are taken at the rising edge, before the pipeline moves on
    always @(posedge Clk) begin
        if (running && rstN && retireValid) begin
            if (expRetire.size() == 0) begin
                $display("test %0d: retire to r%0d has no reference event", testsRun + 1,
                         retireReg);
                testErrors++;
            end else begin
                retireExp = expRetire.pop_front();
                compareField("retireReg", {27'b0, retireExp[36:32]}, {27'b0, retireReg});
                compareField("retireData", retireExp[31:0], retireData);
            end
        end
        if (running && rstN && storeValid) begin
            if (expStore.size() == 0) begin
                $display("test %0d: store to %h has no reference event", testsRun + 1, storeAddr);
                testErrors++;
            end else begin
                storeExp = expStore.pop_front();
                compareField("storeAddr", storeExp[63:32], storeAddr);
                compareField("storeData", storeExp[31:0], storeData);
            end
        end
    end

    always @(negedge rstN) begin
        if (running) begin
            if (expRetire.size() != 0) begin
                $display("test %0d: %0d expected retires never appeared", testsRun + 1,
                         expRetire.size());
                testErrors++;
            end
            if (expStore.size() != 0) begin
                $display("test %0d: %0d expected stores never appeared", testsRun + 1,
                         expStore.size());
                testErrors++;
            end
            testsRun++;
            if (testErrors != 0)
                testsFailed++;
            errorCount += testErrors;
            $display("test %0d %s with %0d errors", testsRun,
                     (testErrors == 0) ? "passed" : "failed", testErrors);
            running = 1'b0;
        end
    end

endmodule

//--- tb/tbMips.sv
`timescale 1ns/1ps

module tbMips;

    localparam int imemDepth = 256;
    localparam int resetCycles = 5;
    localparam int numRandom = 3;
    localparam int numTests = 3 + numRandom;

    logic              Clk;
    logic              rstN;
    logic              imemWe;
    mipsPkg::word_t    imemAddr;
    mipsPkg::word_t    imemData;
    logic              retireValid;
    mipsPkg::regAddr_t retireReg;
    mipsPkg::word_t    retireData;
    logic              storeValid;
    mipsPkg::word_t    storeAddr;
    mipsPkg::word_t    storeData;
    int                testsRun, testsFailed, errorCount;

    int             budget [numTests] = '{60, 40, 120, 150, 150, 150};  // run cycles per test
    mipsPkg::word_t prog [$];
    logic [5:0]     aluFn [8] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
    logic [5:0]     immOp [6] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    mipsCore #(.imemDepth(imemDepth), .dmemDepth(256)) i_mipsCore (.*);

    mipsChecker i_mipsChecker (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // load phase, reset cycles and run cycles of every test, plus margin
    initial begin
        int limit;
        limit = 50;
        for (int t = 0; t < numTests; t++)
            limit += budget[t] + imemDepth + resetCycles + 2;
        #(limit * 4);
        $display("timeout: run did not end within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    function automatic mipsPkg::word_t encodeR(logic [5:0] fn, logic [4:0] rd, rs, rt, sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic mipsPkg::word_t encodeI(logic [5:0] op, logic [4:0] rt, rs,
                                               logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic runProgram(int cycles);
        @(negedge Clk);
        rstN = 1'b0;
        for (int i = 0; i < imemDepth; i++) begin
            imemWe   = 1'b1;
            imemAddr = i * 4;
            imemData = (i < prog.size()) ? prog[i] : '0;  // rest of memory is nop
            @(negedge Clk);
        end
        imemWe = 1'b0;
        repeat (resetCycles) @(negedge Clk);
        rstN = 1'b1;
        repeat (cycles) @(negedge Clk);
        prog.delete();
    endtask

    initial begin
        logic [4:0] rd, rs, rt;
        rstN = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        void'($urandom(86135));

        // R-type and immediate forms, dependencies at distance one and two
        prog.push_back(encodeI(6'h09, 1, 0, 16'h1234));
        prog.push_back(encodeI(6'h09, 2, 0, 16'hfff9));
        foreach (aluFn[i])
            prog.push_back(encodeR(aluFn[i], 3 + i, 1, 2, 0));
        prog.push_back(encodeR(6'h00, 11, 0, 2, 4));
        prog.push_back(encodeR(6'h02, 12, 0, 2, 4));
        foreach (immOp[i])
            prog.push_back(encodeI(immOp[i], 13 + i, 2, 16'h8001));
        prog.push_back(encodeI(6'h0a, 19, 2, 16'h0001));
        prog.push_back(encodeR(6'h21, 20, 19, 18, 0));
        prog.push_back(encodeR(6'h23, 21, 20, 19, 0));
        runProgram(budget[0]);

        // store then load back, load-use, untouched word
        prog.push_back(encodeI(6'h0f, 1, 0, 16'hdead));
        prog.push_back(encodeI(6'h0d, 1, 1, 16'hbeef));
        prog.push_back(encodeI(6'h2b, 1, 0, 16'h0040));
        prog.push_back(encodeI(6'h23, 2, 0, 16'h0040));
        prog.push_back(encodeR(6'h21, 3, 2, 2, 0));
        prog.push_back(encodeI(6'h2b, 3, 0, 16'h03fc));
        prog.push_back(encodeI(6'h23, 4, 0, 16'h03fc));
        prog.push_back(encodeI(6'h23, 5, 0, 16'h0044));
        runProgram(budget[1]);

        // backward loop, then taken and untaken beq/bne
        prog.push_back(encodeI(6'h09, 2, 0, 16'h0004));
        prog.push_back(encodeI(6'h09, 1, 1, 16'h0001));  // loop head
        prog.push_back(encodeR(6'h21, 3, 3, 1, 0));
        prog.push_back(encodeI(6'h05, 2, 1, 16'hfffd));
        prog.push_back(encodeI(6'h04, 2, 1, 16'h0001));
        prog.push_back(encodeI(6'h09, 10, 0, 16'h0bad));  // skipped
        prog.push_back(encodeI(6'h04, 0, 1, 16'h0001));
        prog.push_back(encodeI(6'h09, 4, 0, 16'h0077));
        prog.push_back(encodeI(6'h05, 3, 3, 16'h0001));
        prog.push_back(encodeI(6'h09, 5, 3, 16'h0001));
        prog.push_back(encodeI(6'h04, 0, 0, 16'h0002));
        prog.push_back(encodeI(6'h09, 11, 0, 16'h0001));  // skipped
        prog.push_back(encodeI(6'h09, 12, 0, 16'h0002));  // skipped
        prog.push_back(encodeI(6'h09, 6, 1, 16'h0010));
        runProgram(budget[2]);

        for (int t = 0; t < numRandom; t++) begin
            for (int n = 0; n < 40; n++) begin
                rd = 5'(1 + $urandom % 7);  // few registers, many hazards
                rs = 5'($urandom % 8);
                rt = 5'($urandom % 8);
                case ($urandom % 5)
                    0: prog.push_back(encodeR(aluFn[$urandom % 8], rd, rs, rt, 0));
                    1: prog.push_back(encodeR(($urandom % 2) ? 6'h00 : 6'h02, rd, 0, rt,
                                              5'($urandom)));
                    2: prog.push_back(encodeI(immOp[$urandom % 6], rd, rs, 16'($urandom)));
                    3: prog.push_back(encodeI(6'h23, rd, 0, 16'(4 * ($urandom % 16))));
                    default: prog.push_back(encodeI(6'h2b, rt, 0, 16'(4 * ($urandom % 16))));
                endcase
            end
            runProgram(budget[3 + t]);
        end

        rstN = 1'b0;  // closes the last test
        repeat (2) @(negedge Clk);
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0 && testsRun == numTests)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- all.f
verilog/mipsPkg.sv
verilog/registerFile.sv
verilog/controller.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
tb/mipsChecker.sv
tb/tbMips.sv

//--- run.sh
#!/bin/bash
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tbMips \
    --Mdir obj_dir -o simTbMips \
    && ./obj_dir/simTbMips > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q '\*\* FAIL \*\*' sim.log \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
